// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_norm_round_unit
FILELIST  ?= norm_round_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/norm_round_unit_sva.sv
`timescale 1ns/10ps
`default_nettype none

module norm_round_unit_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_valid,
  input logic                  out_valid,
  input nrm_ctrl_pkg::fflags_t fflags
);
  import nrm_ctrl_pkg::*;

  ////////////////////
  // Pipeline timing
  ////////////////////
  // Two register stages between input and output
  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 2))
    else $error("out_valid does not follow in_valid by two cycles");

  a_reset_low: assert property (@(posedge clk)
    rst |=> !out_valid)   // Synchronous clear
    else $error("out_valid high after a reset cycle");

  ////////////////////
  // Flag consistency
  ////////////////////
  // One classify rule fires at most
  a_nv_dz: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !(fflags[fl_nv] && fflags[fl_dz]))
    else $error("invalid and divide-by-zero both set");

  a_nx_range: assert property (@(posedge clk) disable iff (rst)
    (out_valid && (fflags[fl_of] || fflags[fl_uf])) |-> fflags[fl_nx])
    else $error("overflow or underflow without inexact");

endmodule

bind norm_round_unit norm_round_unit_sva norm_round_unit_sva_inst (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .fflags    (fflags)
);

`default_nettype wire

// File: bench/tb_norm_round_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_norm_round_unit;
  import fp_format_pkg::*;
  import nrm_ctrl_pkg::*;

  // Class bits {div, sqrt, inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan}
  localparam logic [8:0] op_div   = 9'h100;
  localparam logic [8:0] op_sqrt  = 9'h080;
  localparam logic [8:0] c_inf_a  = 9'h040;
  localparam logic [8:0] c_inf_b  = 9'h020;
  localparam logic [8:0] c_zero_a = 9'h010;
  localparam logic [8:0] c_zero_b = 9'h008;
  localparam logic [8:0] c_nan_a  = 9'h004;
  localparam logic [8:0] c_snan   = 9'h001;
  localparam logic [4:0] f_nv = 5'h10;
  localparam logic [4:0] f_dz = 5'h08;
  localparam logic [4:0] f_of = 5'h04;
  localparam logic [4:0] f_uf = 5'h02;
  localparam logic [4:0] f_nx = 5'h01;

  logic     clk;
  logic     rst;
  logic     in_valid;
  man_ext_t man_in;
  exp_ext_t exp_in;
  logic     sign_in;
  logic     is_div;
  logic     is_sqrt;
  logic     inf_a;
  logic     inf_b;
  logic     zero_a;
  logic     zero_b;
  logic     nan_a;
  logic     nan_b;
  logic     snan;
  rm_t      rm;
  fmt_t     fmt;
  logic     out_valid;
  result_t  result;
  fflags_t  fflags;

  // Scoreboard, {flags, result} per item in flight
  logic [36:0] exp_q[$];
  string       name_q[$];
  int          cyc_q[$];
  int          cycle;
  logic [31:0] lfsr;
  logic        timed_out;

  norm_round_unit norm_round_unit_inst (
    .clk (clk), .rst (rst), .in_valid (in_valid), .man_in (man_in), .exp_in (exp_in),
    .sign_in (sign_in), .is_div (is_div), .is_sqrt (is_sqrt), .inf_a (inf_a),
    .inf_b (inf_b), .zero_a (zero_a), .zero_b (zero_b), .nan_a (nan_a), .nan_b (nan_b),
    .snan (snan), .rm (rm), .fmt (fmt), .out_valid (out_valid), .result (result),
    .fflags (fflags)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  ////////////////////
  // Reference rules
  ////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
  endfunction

  // Normal input with the hidden bit set, rounded per mode
  function automatic logic [36:0] expect_normal(input logic s, input logic [27:0] man,
                                                input int e, input logic f16, input rm_t mode);
    logic [23:0] keep;
    logic        rb;
    logic        st;
    logic        up;
    logic [24:0] sum;
    int          eo;
    logic        of;
    logic [31:0] res;
    keep = f16 ? {13'b0, man[27:17]} : man[27:4];
    rb   = f16 ? man[16] : man[3];
    st   = f16 ? |man[15:0] : |man[2:0];
    case (mode)
      rm_nearest:   up = rb & (st | keep[0]);
      rm_minus_inf: up = (rb | st) & s;
      rm_plus_inf:  up = (rb | st) & ~s;
      default:      up = 1'b0;
    endcase
    sum = {1'b0, keep} + 25'(up);
    eo  = (f16 ? sum[11] : sum[24]) ? e + 1 : e;   // Carry bumps the exponent
    of  = (eo == (f16 ? 31 : 255));
    if (f16)
      res = {16'hffff, s, 5'(eo), sum[9:0]};
    else
      res = {s, 8'(eo), sum[22:0]};
    return {2'b00, of, 1'b0, rb | st | of, res};
  endfunction

  function automatic logic [36:0] expect_special(input logic s, input special_t kind,
                                                 input logic f16, input logic [4:0] flags);
    logic [31:0] res;
    case (kind)
      sc_qnan: res = f16 ? 32'hffff_7e00 : 32'h7fc0_0000;
      sc_inf:  res = f16 ? {16'hffff, s, 5'h1f, 10'h0} : {s, 8'hff, 23'h0};
      default: res = f16 ? {16'hffff, s, 15'h0} : {s, 31'h0};
    endcase
    return {flags, res};
  endfunction

  // Negative exponent e shifts right by 1 - e, truncated
  function automatic logic [36:0] expect_denormal(input logic s, input logic [27:0] man,
                                                  input int amt, input logic f16);
    logic [23:0] keep;
    keep = man[27:4] >> amt;
    if (f16)
      return {f_uf | f_nx, 16'hffff, s, 5'h0, keep[22:13]};
    return {f_uf | f_nx, s, 8'h0, keep[22:0]};
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic drive_item(input string name, input logic s, input logic [27:0] man,
                            input int e, input logic f16, input rm_t mode,
                            input logic [8:0] cls, input logic [36:0] expv);
    in_valid = 1'b1;
    sign_in  = s;
    man_in   = man;
    exp_in   = 10'(e);
    fmt      = f16;
    rm       = mode;
    {is_div, is_sqrt, inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan} = cls;
    exp_q.push_back(expv);
    name_q.push_back(name);
    cyc_q.push_back(cycle);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Exact normal, packed straight through
  task automatic send_exact(input string name, input logic f16);
    logic [31:0] v;
    logic        s;
    int          e;
    take_bits(1, v);
    s = v[0];
    if (f16)
    begin
      take_bits(5, v);
      e = int'(v[4:0] % 5'd30) + 1;
      take_bits(10, v);
      drive_item(name, s, {1'b1, v[9:0], 17'h0}, e, 1'b1, rm_nearest, op_div,
                 {5'h0, 16'hffff, s, 5'(e), v[9:0]});
    end
    else
    begin
      take_bits(8, v);
      e = int'(v[7:0] % 8'd254) + 1;
      take_bits(23, v);
      drive_item(name, s, {1'b1, v[22:0], 4'h0}, e, 1'b0, rm_nearest, op_div,
                 {5'h0, s, 8'(e), v[22:0]});
    end
  endtask

  task automatic round_all_modes(input string name, input logic [27:0] man, input int e,
                                 input logic f16);
    for (int sg = 0; sg < 2; sg++)
      for (int m = 0; m < 4; m++)
        drive_item(name, sg[0], man, e, f16, rm_t'(m), op_div,
                   expect_normal(sg[0], man, e, f16, rm_t'(m)));
  endtask

  task automatic fail_stop();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic drain(output logic late);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 100)
    begin
      @(posedge clk);
      waited++;
    end
    late = (exp_q.size() != 0);
    #1;
  endtask

  ////////////////////
  // Output checks
  ////////////////////
  always @(negedge clk)
  begin : check_output
    logic [36:0] expv;
    string       name;
    int          sent;
    if (!rst && out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("A result came out with no item in flight");
        fail_stop();
      end
      else
      begin
        expv = exp_q.pop_front();
        name = name_q.pop_front();
        sent = cyc_q.pop_front();
        a_lat: assert (cycle == sent + 2)
        else
        begin
          $display("Fail %s latency expected %0d actual %0d", name, sent + 2, cycle);
          fail_stop();
        end
        a_res: assert (result == expv[31:0])
        else
        begin
          $display("Fail %s result expected %h actual %h", name, expv[31:0], result);
          fail_stop();
        end
        a_flg: assert (fflags == expv[36:32])
        else
        begin
          $display("Fail %s flags expected %b actual %b", name, expv[36:32], fflags);
          fail_stop();
        end
      end
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    cycle = 0;
    lfsr = 32'had4d;
    in_valid = 1'b0;
    man_in = '0;
    exp_in = '0;
    sign_in = 1'b0;
    {is_div, is_sqrt, inf_a, inf_b, zero_a, zero_b, nan_a, nan_b, snan} = '0;
    rm = rm_nearest;
    fmt = fmt_fp32;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);

    // Exact normals, one apart
    for (int i = 0; i < 6; i++)
    begin
      send_exact("exact_fp32", 1'b0);
      idle(1);
      send_exact("exact_fp16", 1'b1);
    end

    // Round bit and sticky patterns, then the carry case
    round_all_modes("rnd32_tie", {1'b1, 23'h12_3456, 4'b1000}, 100, 1'b0);
    round_all_modes("rnd32_tie_odd", {1'b1, 23'h12_3457, 4'b1000}, 100, 1'b0);
    round_all_modes("rnd32_11", {1'b1, 23'h12_3456, 4'b1001}, 100, 1'b0);
    round_all_modes("rnd32_01", {1'b1, 23'h12_3456, 4'b0001}, 100, 1'b0);
    round_all_modes("rnd32_carry", {1'b1, 23'h7f_ffff, 4'b1000}, 100, 1'b0);
    round_all_modes("rnd16_tie", {1'b1, 10'h2a4, 1'b1, 16'h0000}, 20, 1'b1);
    round_all_modes("rnd16_tie_odd", {1'b1, 10'h2a5, 1'b1, 16'h0000}, 20, 1'b1);
    round_all_modes("rnd16_11", {1'b1, 10'h2a4, 1'b1, 16'h0001}, 20, 1'b1);
    round_all_modes("rnd16_01", {1'b1, 10'h2a4, 1'b0, 16'h8000}, 20, 1'b1);
    round_all_modes("rnd16_carry", {1'b1, 10'h3ff, 1'b1, 16'h0000}, 20, 1'b1);
    idle(3);

    // One item per classify rule
    drive_item("qnan_a", 1'b1, 28'h800_0000, 1, 1'b0, rm_nearest, op_div | c_nan_a,
               expect_special(1'b0, sc_qnan, 1'b0, 5'h0));
    drive_item("snan_a", 1'b0, 28'h800_0000, 1, 1'b1, rm_nearest, op_div | c_nan_a | c_snan,
               expect_special(1'b0, sc_qnan, 1'b1, f_nv));
    drive_item("inf_over_inf", 1'b1, 28'h800_0000, 1, 1'b0, rm_nearest,
               op_div | c_inf_a | c_inf_b, expect_special(1'b0, sc_qnan, 1'b0, f_nv));
    drive_item("sqrt_minus_inf", 1'b1, 28'h800_0000, 1, 1'b0, rm_nearest, op_sqrt | c_inf_a,
               expect_special(1'b0, sc_qnan, 1'b0, f_nv));
    drive_item("inf_over_x", 1'b0, 28'h800_0000, 1, 1'b1, rm_nearest, op_div | c_inf_a,
               expect_special(1'b0, sc_inf, 1'b1, 5'h0));
    drive_item("x_over_inf", 1'b1, 28'h800_0000, 1, 1'b0, rm_nearest, op_div | c_inf_b,
               expect_special(1'b1, sc_zero, 1'b0, 5'h0));
    drive_item("zero_over_zero", 1'b0, 28'h800_0000, 1, 1'b0, rm_nearest,
               op_div | c_zero_a | c_zero_b, expect_special(1'b0, sc_qnan, 1'b0, f_nv));
    drive_item("sqrt_zero", 1'b1, 28'h800_0000, 1, 1'b1, rm_nearest, op_sqrt | c_zero_a,
               expect_special(1'b1, sc_zero, 1'b1, 5'h0));
    drive_item("x_over_zero", 1'b1, 28'h800_0000, 1, 1'b0, rm_nearest, op_div | c_zero_b,
               expect_special(1'b1, sc_inf, 1'b0, f_dz));
    drive_item("sqrt_negative", 1'b1, 28'h800_0000, 1, 1'b0, rm_nearest, op_sqrt,
               expect_special(1'b0, sc_qnan, 1'b0, f_nv));
    idle(2);

    // Exponent out of range on both ends
    drive_item("overflow32", 1'b0, 28'h800_0000, 300, 1'b0, rm_nearest, op_div,
               expect_special(1'b0, sc_inf, 1'b0, f_of | f_nx));
    drive_item("overflow32_max", 1'b1, 28'h800_0000, 255, 1'b0, rm_nearest, op_div,
               expect_special(1'b1, sc_inf, 1'b0, f_of | f_nx));
    drive_item("overflow16", 1'b1, 28'h800_0000, 40, 1'b1, rm_nearest, op_div,
               expect_special(1'b1, sc_inf, 1'b1, f_of | f_nx));
    drive_item("denorm32", 1'b0, 28'habc_def0, -3, 1'b0, rm_trunc, op_div,
               expect_denormal(1'b0, 28'habc_def0, 4, 1'b0));
    drive_item("denorm16", 1'b1, 28'hd5a_0000, -2, 1'b1, rm_trunc, op_div,
               expect_denormal(1'b1, 28'hd5a_0000, 3, 1'b1));
    idle(4);

    // Back-to-back burst, then spaced items
    for (int i = 0; i < 8; i++)
      send_exact("burst", i[0]);
    idle(5);
    for (int i = 0; i < 4; i++)
    begin
      send_exact("spaced", i[0]);
      idle(i + 1);
    end

    drain(timed_out);
    if (timed_out)
    begin
      $display("Results still missing after waiting 100 cycles");
      $display("Simulation FAILED");
      $fatal(1);
    end
    else
    begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: norm_round_unit.f
rtl/fp_format_pkg.sv
rtl/nrm_ctrl_pkg.sv
rtl/nrm_classify.sv
rtl/nrm_normalize.sv
rtl/nrm_round.sv
rtl/norm_round_unit.sv
bench/norm_round_unit_sva.sv
bench/tb_norm_round_unit.sv

// File: rtl/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

  ////////////////////
  // Format widths
  ////////////////////
  localparam int unsigned exp_w_fp32 = 8;
  localparam int unsigned exp_w_fp16 = 5;
  localparam int unsigned man_w_fp32 = 23;
  localparam int unsigned man_w_fp16 = 10;
  localparam int unsigned guard_w    = 4;    // Extra low bits from the divider

  // Exponent biases
  localparam int unsigned bias_fp32 = 127;
  localparam int unsigned bias_fp16 = 15;

  ////////////////////
  // Datapath vectors
  ////////////////////
  typedef logic        [man_w_fp32+guard_w:0]  man_ext_t;   // Hidden, fraction, guard
  typedef logic signed [exp_w_fp32+1:0]        exp_ext_t;   // Room for sign and carry
  typedef logic        [man_w_fp32:0]          man_norm_t;  // Hidden plus fraction
  typedef logic        [man_w_fp32+guard_w:0]  man_low_t;   // Shifted-out bits
  typedef logic        [exp_w_fp32-1:0]        exp_res_t;
  typedef logic        [31:0]                  result_t;

  // All-ones exponent per format, the infinity/NaN code
  localparam exp_ext_t exp_max_fp32 = exp_ext_t'(2 * bias_fp32 + 1);
  localparam exp_ext_t exp_max_fp16 = exp_ext_t'(2 * bias_fp16 + 1);

  localparam logic [man_w_fp32-1:0] qnan_man_fp32 = 23'h40_0000;  // Quiet bit only
  localparam exp_ext_t              exp_one       = 10'sd1;

endpackage

`default_nettype wire

// File: rtl/norm_round_unit.sv
`timescale 1ns/10ps
`default_nettype none

module norm_round_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  fp_format_pkg::man_ext_t man_in,
  input  fp_format_pkg::exp_ext_t exp_in,
  input  logic                    sign_in,
  input  logic                    is_div,
  input  logic                    is_sqrt,
  input  logic                    inf_a,
  input  logic                    inf_b,
  input  logic                    zero_a,
  input  logic                    zero_b,
  input  logic                    nan_a,
  input  logic                    nan_b,
  input  logic                    snan,
  input  nrm_ctrl_pkg::rm_t       rm,
  input  nrm_ctrl_pkg::fmt_t      fmt,
  output logic                    out_valid,
  output fp_format_pkg::result_t  result,
  output nrm_ctrl_pkg::fflags_t   fflags
);
  import fp_format_pkg::*;
  import nrm_ctrl_pkg::*;

  // Classify to normalize, same cycle
  special_t  special_class;
  logic      special_sign;
  logic      flag_nv;
  logic      flag_dz;

  // Stage one to round
  logic      s1_valid;
  logic      s1_sign;
  man_norm_t s1_man;
  man_low_t  s1_low;
  exp_res_t  s1_exp;
  fmt_t      s1_fmt;
  rm_t       s1_rm;
  special_t  s1_class;
  fflags_t   s1_flags;

  nrm_classify nrm_classify_inst (
    .sign_in       (sign_in),
    .is_div        (is_div),
    .is_sqrt       (is_sqrt),
    .inf_a         (inf_a),
    .inf_b         (inf_b),
    .zero_a        (zero_a),
    .zero_b        (zero_b),
    .nan_a         (nan_a),
    .nan_b         (nan_b),
    .snan          (snan),
    .special_class (special_class),
    .special_sign  (special_sign),
    .flag_nv       (flag_nv),
    .flag_dz       (flag_dz)
  );

  nrm_normalize nrm_normalize_inst (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .man_in        (man_in),
    .exp_in        (exp_in),
    .sign_in       (sign_in),
    .fmt           (fmt),
    .rm            (rm),
    .special_class (special_class),
    .special_sign  (special_sign),
    .flag_nv       (flag_nv),
    .flag_dz       (flag_dz),
    .s1_valid      (s1_valid),
    .s1_sign       (s1_sign),
    .s1_man        (s1_man),
    .s1_low        (s1_low),
    .s1_exp        (s1_exp),
    .s1_fmt        (s1_fmt),
    .s1_rm         (s1_rm),
    .s1_class      (s1_class),
    .s1_flags      (s1_flags)
  );

  nrm_round nrm_round_inst (
    .clk       (clk),
    .rst       (rst),
    .s1_valid  (s1_valid),
    .s1_sign   (s1_sign),
    .s1_man    (s1_man),
    .s1_low    (s1_low),
    .s1_exp    (s1_exp),
    .s1_fmt    (s1_fmt),
    .s1_rm     (s1_rm),
    .s1_class  (s1_class),
    .s1_flags  (s1_flags),
    .out_valid (out_valid),
    .result    (result),
    .fflags    (fflags)
  );

endmodule

`default_nettype wire

// File: rtl/nrm_classify.sv
`timescale 1ns/10ps
`default_nettype none

module nrm_classify (
  input  logic                   sign_in,
  input  logic                   is_div,
  input  logic                   is_sqrt,
  input  logic                   inf_a,
  input  logic                   inf_b,
  input  logic                   zero_a,
  input  logic                   zero_b,
  input  logic                   nan_a,
  input  logic                   nan_b,
  input  logic                   snan,
  output nrm_ctrl_pkg::special_t special_class,
  output logic                   special_sign,
  output logic                   flag_nv,
  output logic                   flag_dz
);
  import nrm_ctrl_pkg::*;

  // Priority chain, first match wins
  always_comb
  begin
    special_class = sc_none;
    special_sign  = sign_in;   // Sign of inf and zero results
    flag_nv       = 1'b0;
    flag_dz       = 1'b0;

    if (nan_a || (nan_b && is_div))
    begin
      special_class = sc_qnan;
      special_sign  = 1'b0;    // Canonical NaN is positive
      flag_nv       = snan;    // Only a signalling input is invalid
    end
    else if (inf_a && is_div && inf_b)
    begin
      special_class = sc_qnan;  // inf / inf
      special_sign  = 1'b0;
      flag_nv       = 1'b1;
    end
    else if (inf_a && is_sqrt && sign_in)
    begin
      special_class = sc_qnan;  // sqrt(-inf)
      special_sign  = 1'b0;
      flag_nv       = 1'b1;
    end
    else if (inf_a)
    begin
      special_class = sc_inf;
    end
    else if (is_div && inf_b)
    begin
      special_class = sc_zero;  // x / inf, exact zero
    end
    else if (zero_a && is_div && zero_b)
    begin
      special_class = sc_qnan;  // 0 / 0
      special_sign  = 1'b0;
      flag_nv       = 1'b1;
    end
    else if (zero_a)
    begin
      special_class = sc_zero;  // Keeps sign, so sqrt(-0) = -0
    end
    else if (is_div && zero_b)
    begin
      special_class = sc_inf;
      flag_dz       = 1'b1;
    end
    else if (is_sqrt && sign_in)
    begin
      // Square root of a negative finite value
      special_class = sc_qnan;
      special_sign  = 1'b0;
      flag_nv       = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/nrm_ctrl_pkg.sv
`default_nettype none

package nrm_ctrl_pkg;

  ////////////////////
  // Rounding modes
  ////////////////////
  typedef logic [2:0] rm_t;
  localparam rm_t rm_nearest   = 3'd0;  // Ties to even
  localparam rm_t rm_trunc     = 3'd1;
  localparam rm_t rm_minus_inf = 3'd2;
  localparam rm_t rm_plus_inf  = 3'd3;  // Codes above 3 truncate

  // Format select
  typedef logic fmt_t;
  localparam fmt_t fmt_fp32 = 1'b0;
  localparam fmt_t fmt_fp16 = 1'b1;

  ////////////////////
  // Exception flags
  ////////////////////
  typedef logic [4:0] fflags_t;  // {NV, DZ, OF, UF, NX}
  localparam int unsigned fl_nv = 4;
  localparam int unsigned fl_dz = 3;
  localparam int unsigned fl_of = 2;
  localparam int unsigned fl_uf = 1;
  localparam int unsigned fl_nx = 0;

  // Result class decided before rounding
  typedef enum logic [1:0] {sc_none, sc_qnan, sc_inf, sc_zero} special_t;

endpackage

`default_nettype wire

// File: rtl/nrm_normalize.sv
`timescale 1ns/10ps
`default_nettype none

module nrm_normalize (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  fp_format_pkg::man_ext_t   man_in,
  input  fp_format_pkg::exp_ext_t   exp_in,
  input  logic                      sign_in,
  input  nrm_ctrl_pkg::fmt_t        fmt,
  input  nrm_ctrl_pkg::rm_t         rm,
  input  nrm_ctrl_pkg::special_t    special_class,
  input  logic                      special_sign,
  input  logic                      flag_nv,
  input  logic                      flag_dz,
  output logic                      s1_valid,
  output logic                      s1_sign,
  output fp_format_pkg::man_norm_t  s1_man,
  output fp_format_pkg::man_low_t   s1_low,
  output fp_format_pkg::exp_res_t   s1_exp,
  output nrm_ctrl_pkg::fmt_t        s1_fmt,
  output nrm_ctrl_pkg::rm_t         s1_rm,
  output nrm_ctrl_pkg::special_t    s1_class,
  output nrm_ctrl_pkg::fflags_t     s1_flags
);
  import fp_format_pkg::*;
  import nrm_ctrl_pkg::*;

  localparam int unsigned hid_pos = man_w_fp32 + guard_w;  // Hidden bit of man_in
  localparam int unsigned nw      = $bits(man_norm_t);
  localparam int unsigned lw      = $bits(man_low_t);

  exp_ext_t                exp_max;   // Inf code of the selected format
  exp_ext_t                exp_dec;
  logic [$bits(exp_ext_t)-1:0] rs_amt;  // Right shift for negative exponents
  logic [nw+lw-1:0]        rs_vec;
  man_norm_t               man_nrm;
  man_low_t                low_nrm;
  exp_res_t                exp_nrm;
  logic                    of_nrm;
  logic                    uf_nrm;
  logic                    is_none;
  fflags_t                 flags_nrm;

  assign exp_max = (fmt == fmt_fp32) ? exp_max_fp32 : exp_max_fp16;
  assign exp_dec = exp_in - exp_one;
  assign rs_amt  = exp_one - exp_in;                   // 1 - e, shifts to denormal scale
  assign rs_vec  = {man_in, {nw{1'b0}}} >> rs_amt;     // Low part keeps the sticky source
  assign is_none = (special_class == sc_none);

  ////////////////////
  // Normalization
  ////////////////////
  always_comb
  begin
    // Default is 1.xxx, leading one already in place
    man_nrm = man_in[hid_pos -: nw];
    low_nrm = {man_in[guard_w-1:0], {(lw-guard_w){1'b0}}};
    exp_nrm = exp_in[exp_w_fp32-1:0];
    of_nrm  = 1'b0;
    uf_nrm  = 1'b0;

    if (exp_in == '0)
    begin
      // Exponent zero, one step down to denormal scale
      man_nrm = {1'b0, man_in[hid_pos -: nw-1]};
      low_nrm = {man_in[guard_w:0], {(lw-guard_w-1){1'b0}}};
      exp_nrm = '0;
      uf_nrm  = |man_in;   // All-zero mantissa is a plain zero
    end
    else if (exp_in == exp_one && !man_in[hid_pos])
    begin
      exp_nrm = '0;        // 0.1xx at exponent one is denormal
      uf_nrm  = 1'b1;
    end
    else if (exp_in < 0)
    begin
      {man_nrm, low_nrm} = rs_vec;
      exp_nrm = '0;
      uf_nrm  = 1'b1;
    end
    else if (exp_in > exp_max || (exp_in == exp_max && man_in[hid_pos]))
    begin
      // Past the format range, force infinity
      man_nrm = '0;
      low_nrm = '0;
      exp_nrm = '1;        // Round stage takes the low bits for FP16
      of_nrm  = 1'b1;
    end
    else if (!man_in[hid_pos])
    begin
      // 0.1xx, shift left one and take one off the exponent
      man_nrm = man_in[hid_pos-1 -: nw];
      low_nrm = {man_in[guard_w-2:0], {(lw-guard_w+1){1'b0}}};
      exp_nrm = exp_dec[exp_w_fp32-1:0];
    end
  end

  // Range flags only count for ordinary numbers
  always_comb
  begin
    flags_nrm        = '0;
    flags_nrm[fl_nv] = flag_nv;
    flags_nrm[fl_dz] = flag_dz;
    flags_nrm[fl_of] = of_nrm & is_none;
    flags_nrm[fl_uf] = uf_nrm & is_none;
  end

  ////////////////////
  // Stage one regs
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
      s1_valid <= 1'b0;
    else
      s1_valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      s1_sign  <= is_none ? sign_in : special_sign;
      s1_man   <= man_nrm;
      s1_low   <= low_nrm;
      s1_exp   <= exp_nrm;
      s1_fmt   <= fmt;
      s1_rm    <= rm;
      s1_class <= special_class;
      s1_flags <= flags_nrm;   // NX filled in by the round stage
    end
  end

endmodule

`default_nettype wire

// File: rtl/nrm_round.sv
`timescale 1ns/10ps
`default_nettype none

module nrm_round (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      s1_valid,
  input  logic                      s1_sign,
  input  fp_format_pkg::man_norm_t  s1_man,
  input  fp_format_pkg::man_low_t   s1_low,
  input  fp_format_pkg::exp_res_t   s1_exp,
  input  nrm_ctrl_pkg::fmt_t        s1_fmt,
  input  nrm_ctrl_pkg::rm_t         s1_rm,
  input  nrm_ctrl_pkg::special_t    s1_class,
  input  nrm_ctrl_pkg::fflags_t     s1_flags,
  output logic                      out_valid,
  output fp_format_pkg::result_t    result,
  output nrm_ctrl_pkg::fflags_t     fflags
);
  import fp_format_pkg::*;
  import nrm_ctrl_pkg::*;

  localparam int unsigned nw      = $bits(man_norm_t);
  localparam int unsigned lw      = $bits(man_low_t);
  localparam int unsigned f16_lsb = man_w_fp32 - man_w_fp16;  // FP16 lsb inside s1_man

  logic                  is_fp16;
  logic                  is_none;
  logic                  lsb;        // Lowest kept bit
  logic                  rnd_bit;    // First dropped bit
  logic                  sticky;     // OR of all dropped bits below it
  logic                  dropped;
  logic                  round_up;
  logic [nw:0]           man_inc;
  logic [nw:0]           man_up;     // One extra bit for the carry
  logic                  renorm;
  logic                  exp_inc;
  logic [man_w_fp32-1:0] frac_rnd;
  exp_res_t              exp_rnd;
  exp_res_t              exp_top;
  logic                  of_rnd;
  exp_res_t              exp_out;
  logic [man_w_fp32-1:0] frac_out;
  result_t               res_nxt;
  fflags_t               flags_nxt;

  assign is_fp16 = (s1_fmt == fmt_fp16);
  assign is_none = (s1_class == sc_none);

  ////////////////////
  // Round decision
  ////////////////////
  always_comb
  begin
    if (is_fp16)
    begin
      lsb     = s1_man[f16_lsb];
      rnd_bit = s1_man[f16_lsb-1];
      sticky  = (|s1_man[f16_lsb-2:0]) | (|s1_low);
    end
    else
    begin
      lsb     = s1_man[0];
      rnd_bit = s1_low[lw-1];
      sticky  = |s1_low[lw-2:0];
    end
  end

  assign dropped = rnd_bit | sticky;

  always_comb
  begin
    case (s1_rm)
      rm_nearest:   round_up = rnd_bit & (sticky | lsb);  // Ties go to even
      rm_trunc:     round_up = 1'b0;
      rm_plus_inf:  round_up = dropped & ~s1_sign;
      rm_minus_inf: round_up = dropped & s1_sign;
      default:      round_up = 1'b0;                      // Unused codes truncate
    endcase
  end

  // Increment lands on the lsb of the format
  always_comb
  begin
    man_inc = '0;
    if (is_fp16)
      man_inc[f16_lsb] = round_up;
    else
      man_inc[0] = round_up;
  end

  ////////////////////
  // Renormalize
  ////////////////////
  assign man_up   = {1'b0, s1_man} + man_inc;
  assign renorm   = man_up[nw];   // 1.11..1 rolled over to 10.00..0
  assign frac_rnd = renorm ? man_up[nw-1:1] : man_up[nw-2:0];

  // A denormal that rounds up into the hidden bit becomes the smallest normal
  assign exp_inc  = renorm | ((s1_exp == '0) & man_up[nw-1]);
  assign exp_rnd  = s1_exp + exp_res_t'(exp_inc);

  assign exp_top  = is_fp16 ? exp_res_t'(exp_max_fp16) : exp_res_t'(exp_max_fp32);
  assign of_rnd   = is_none & exp_inc & (exp_rnd == exp_top);   // Carry into inf

  ////////////////////
  // Pack and flags
  ////////////////////
  always_comb
  begin
    case (s1_class)
      sc_qnan:
      begin
        exp_out  = '1;
        frac_out = qnan_man_fp32;   // Top fraction bit, also right for FP16
      end
      sc_inf:
      begin
        exp_out  = '1;
        frac_out = '0;
      end
      sc_zero:
      begin
        exp_out  = '0;
        frac_out = '0;
      end
      default:
      begin
        exp_out  = exp_rnd;
        frac_out = frac_rnd;
      end
    endcase

    if (is_fp16)   // NaN-boxed half in the upper 16 bits
      res_nxt = {{16{1'b1}}, s1_sign, exp_out[exp_w_fp16-1:0],
                 frac_out[man_w_fp32-1 -: man_w_fp16]};
    else
      res_nxt = {s1_sign, exp_out, frac_out};
  end

  always_comb
  begin
    flags_nxt        = s1_flags;
    flags_nxt[fl_of] = s1_flags[fl_of] | of_rnd;
    flags_nxt[fl_nx] = (is_none & dropped) | flags_nxt[fl_of] | s1_flags[fl_uf];
  end

  ////////////////////
  // Output regs
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= s1_valid;
  end

  always_ff @(posedge clk)
  begin
    if (s1_valid)   // Holds until the next item
    begin
      result <= res_nxt;
      fflags <= flags_nxt;
    end
  end

endmodule

`default_nettype wire
